//--- source/mf_config.svh
/* median filter configuration */

`ifndef MF_CONFIG_SVH
`define MF_CONFIG_SVH

// pixel and geometry widths
`define MF_PIX_W   8
`define MF_DIM_W   10

// pixel memory address width, 1024 pixels
`define MF_ADDR_W  10

// host port
`define MF_MODE_W  2
`define MF_BUS_W   32

// taps in the 3x3 window
`define MF_WIN     9

`endif

//--- source/mf_pkg.sv
/* median filter types */

`include "mf_config.svh"

package mf_pkg;

    typedef logic [`MF_PIX_W-1:0]  pixel_t;
    typedef logic [`MF_DIM_W-1:0]  dim_t;
    typedef logic [`MF_ADDR_W-1:0] pix_addr_t;
    typedef logic [`MF_BUS_W-1:0]  bus_t;

    typedef enum logic [`MF_MODE_W-1:0] {
        MODE_PIXEL,
        MODE_CTRL,
        MODE_WIDTH,
        MODE_HEIGHT
    } host_mode_t;

    typedef struct packed {
        logic       en;
        logic       we;
        host_mode_t mode;
        pix_addr_t  addr;
        bus_t       data;
    } host_req_t;

    typedef struct packed {
        logic      en;
        logic      we;
        pix_addr_t addr;
        pixel_t    data;
    } ram_req_t;

    typedef struct packed {
        dim_t      row;
        dim_t      col;
        pix_addr_t base;    // address of column 0 of the current row
    } pix_pos_t;

    typedef pixel_t [`MF_WIN-1:0] window_t;    // tap 0 upper left

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_EXEC,
        ST_DONE
    } seq_state_t;

endpackage

//--- source/mf_pixel_ram.sv
/* single-port pixel RAM */

`include "mf_config.svh"

module mf_pixel_ram #(
    parameter int DEPTH = 2 ** `MF_ADDR_W
) (
    input  logic             CLK,
    input  mf_pkg::ram_req_t req_i,
    output mf_pkg::pixel_t   rdata_o
);
    import mf_pkg::*;

    pixel_t mem [DEPTH];
    pixel_t rdata_r;

    // read data one cycle after the request
    always_ff @(posedge CLK) begin
        if (req_i.en) begin
            if (req_i.we) begin
                mem[req_i.addr] <= req_i.data;
            end else begin
                rdata_r <= mem[req_i.addr];
            end
        end
    end

    assign rdata_o = rdata_r;

endmodule

//--- source/mf_median_sort.sv
/* odd-even transposition median sorter */

`include "mf_config.svh"

module mf_median_sort (
    input  logic            CLK,
    input  logic            RST,
    input  logic            window_valid_i,
    input  mf_pkg::window_t window_i,
    output logic            median_valid_o,
    output mf_pkg::pixel_t  median_o
);
    import mf_pkg::*;

    localparam int PASS_W = $clog2(`MF_WIN);

    window_t           arr_r;
    logic [PASS_W-1:0] pass_r;
    logic              run_r;
    logic              valid_r;

    // one compare-exchange pass, odd selects pairs (1,2),(3,4)...
    function automatic window_t cx_pass(input window_t w, input logic odd);
        window_t r;
        pixel_t  t;
        r = w;
        for (int i = 0; i < `MF_WIN - 1; i++) begin
            if (i[0] == odd && r[i] > r[i+1]) begin
                t      = r[i];
                r[i]   = r[i+1];
                r[i+1] = t;
            end
        end
        return r;
    endfunction

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            pass_r  <= '0;
            run_r   <= 1'b0;
            valid_r <= 1'b0;
        end else begin
            valid_r <= run_r && (pass_r == PASS_W'(`MF_WIN - 1));
            if (window_valid_i) begin
                run_r  <= 1'b1;
                pass_r <= PASS_W'(1);    // pass 0 runs on load
            end else if (run_r) begin
                pass_r <= pass_r + PASS_W'(1);
                if (pass_r == PASS_W'(`MF_WIN - 1)) run_r <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (window_valid_i) arr_r <= cx_pass(window_i, 1'b0);
        else if (run_r) arr_r <= cx_pass(arr_r, pass_r[0]);
    end

    assign median_valid_o = valid_r;
    assign median_o       = arr_r[`MF_WIN/2];

endmodule

//--- source/mf_window_fetch.sv
/* 3x3 window fetch */

`include "mf_config.svh"

module mf_window_fetch (
    input  logic             CLK,
    input  logic             RST,
    input  logic             fetch_start_i,
    input  mf_pkg::pix_pos_t pos_i,
    input  mf_pkg::dim_t     width_i,
    input  mf_pkg::dim_t     height_i,
    input  mf_pkg::pixel_t   src_rdata_i,
    output mf_pkg::ram_req_t src_req_o,
    output logic             window_valid_o,
    output mf_pkg::window_t  window_o
);
    import mf_pkg::*;

    localparam int TAP_W = $clog2(`MF_WIN);

    logic [TAP_W-1:0] tap_r;
    logic             run_r;
    logic [TAP_W-1:0] cur_tap;
    logic             issue;
    logic             cap_en_r;
    logic [TAP_W-1:0] cap_tap_r;
    logic             cap_zero;
    logic             window_valid_r;
    window_t          window_r;
    pix_addr_t        row_base;
    pix_addr_t        rd_addr;

    // window row of a tap, 0 above the centre
    function automatic logic [1:0] tap_row(input logic [TAP_W-1:0] t);
        if (t < TAP_W'(3)) return 2'd0;
        else if (t < TAP_W'(6)) return 2'd1;
        else return 2'd2;
    endfunction

    function automatic logic [1:0] tap_col(input logic [TAP_W-1:0] t);
        logic [TAP_W-1:0] rem;
        rem = t - TAP_W'(3) * TAP_W'(tap_row(t));
        return rem[1:0];
    endfunction

    // first tap goes out in the fetch_start cycle
    assign issue   = fetch_start_i || run_r;
    assign cur_tap = fetch_start_i ? '0 : tap_r;

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            tap_r          <= '0;
            run_r          <= 1'b0;
            cap_en_r       <= 1'b0;
            cap_tap_r      <= '0;
            window_valid_r <= 1'b0;
        end else begin
            if (issue) begin
                if (cur_tap == TAP_W'(`MF_WIN - 1)) begin
                    run_r <= 1'b0;
                    tap_r <= '0;
                end else begin
                    run_r <= 1'b1;
                    tap_r <= cur_tap + TAP_W'(1);
                end
            end
            cap_en_r       <= issue;    // one cycle memory latency
            cap_tap_r      <= cur_tap;
            window_valid_r <= cap_en_r && (cap_tap_r == TAP_W'(`MF_WIN - 1));
        end
    end

    // neighbour address, row then column offset
    always_comb begin
        case (tap_row(cur_tap))
            2'd0:    row_base = pos_i.base - pix_addr_t'(width_i);
            2'd1:    row_base = pos_i.base;
            default: row_base = pos_i.base + pix_addr_t'(width_i);
        endcase
        rd_addr = row_base + pix_addr_t'(pos_i.col) + pix_addr_t'(tap_col(cur_tap))
                  - pix_addr_t'(1);
    end

    always_comb begin
        src_req_o.en   = issue;
        src_req_o.we   = 1'b0;
        src_req_o.addr = rd_addr;
        src_req_o.data = '0;
    end

    // border taps read as zero
    assign cap_zero = (tap_row(cap_tap_r) == 2'd0 && pos_i.row == '0) ||
                      (tap_row(cap_tap_r) == 2'd2 && pos_i.row == height_i - dim_t'(1)) ||
                      (tap_col(cap_tap_r) == 2'd0 && pos_i.col == '0) ||
                      (tap_col(cap_tap_r) == 2'd2 && pos_i.col == width_i - dim_t'(1));

    always_ff @(posedge CLK) begin
        if (cap_en_r) begin
            window_r[cap_tap_r] <= cap_zero ? '0 : src_rdata_i;
        end
    end

    assign window_valid_o = window_valid_r;
    assign window_o       = window_r;

endmodule

//--- source/mf_sequencer.sv
/* frame sequencer */

module mf_sequencer (
    input  logic             CLK,
    input  logic             RST,
    input  logic             start_i,
    input  mf_pkg::dim_t     width_i,
    input  mf_pkg::dim_t     height_i,
    input  logic             median_valid_i,
    input  mf_pkg::pixel_t   median_i,
    output logic             busy_o,
    output logic             done_o,
    output logic             fetch_start_o,
    output mf_pkg::pix_pos_t pos_o,
    output mf_pkg::ram_req_t res_req_o
);
    import mf_pkg::*;

    seq_state_t state_r;
    seq_state_t state_nx;
    dim_t       row_r;
    dim_t       col_r;
    pix_addr_t  base_r;
    logic       fetch_start_r;
    logic       last_col;
    logic       last_pix;
    logic       wr_en;

    assign last_col = (col_r == width_i - dim_t'(1));
    assign last_pix = last_col && (row_r == height_i - dim_t'(1));
    assign wr_en    = median_valid_i && (state_r == ST_EXEC);

    always_comb begin
        state_nx = state_r;
        case (state_r)
            ST_IDLE: if (start_i) state_nx = ST_EXEC;
            ST_EXEC: if (wr_en && last_pix) state_nx = ST_DONE;
            ST_DONE: if (!start_i) state_nx = ST_IDLE;    // host clears start
            default: state_nx = ST_IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            state_r       <= ST_IDLE;
            fetch_start_r <= 1'b0;
            row_r         <= '0;
            col_r         <= '0;
            base_r        <= '0;
        end else begin
            state_r       <= state_nx;
            fetch_start_r <= (state_r == ST_IDLE && start_i) || (wr_en && !last_pix);
            if (state_r == ST_IDLE) begin
                row_r  <= '0;
                col_r  <= '0;
                base_r <= '0;
            end else if (wr_en && !last_pix) begin
                if (last_col) begin
                    col_r  <= '0;
                    row_r  <= row_r + dim_t'(1);
                    base_r <= base_r + pix_addr_t'(width_i);    // next row start
                end else begin
                    col_r <= col_r + dim_t'(1);
                end
            end
        end
    end

    // result goes to the current position
    always_comb begin
        res_req_o.en   = wr_en;
        res_req_o.we   = wr_en;
        res_req_o.addr = base_r + pix_addr_t'(col_r);
        res_req_o.data = median_i;
    end

    assign busy_o        = (state_r == ST_EXEC);
    assign done_o        = (state_r == ST_DONE);
    assign fetch_start_o = fetch_start_r;
    assign pos_o         = '{row: row_r, col: col_r, base: base_r};

endmodule

//--- source/mf_host_port.sv
/* host port and memory steering */

`include "mf_config.svh"

module mf_host_port (
    input  logic              CLK,
    input  logic              RST,
    input  mf_pkg::host_req_t host_req_i,
    input  logic              busy_i,
    input  logic              done_i,
    input  mf_pkg::ram_req_t  src_req_i,
    input  mf_pkg::ram_req_t  res_req_i,
    input  mf_pkg::pixel_t    res_rdata_i,
    output mf_pkg::ram_req_t  src_req_o,
    output mf_pkg::ram_req_t  res_req_o,
    output logic              start_o,
    output mf_pkg::dim_t      width_o,
    output mf_pkg::dim_t      height_o,
    output mf_pkg::bus_t      douta_o
);
    import mf_pkg::*;

    logic       start_r;
    dim_t       width_r;
    dim_t       height_r;
    logic       rd_en_r;
    host_mode_t rd_mode_r;
    logic       pix_acc;

    assign pix_acc = host_req_i.en && (host_req_i.mode == MODE_PIXEL);

    always_ff @(posedge CLK or negedge RST) begin
        if (!RST) begin
            start_r   <= 1'b0;
            width_r   <= '0;
            height_r  <= '0;
            rd_en_r   <= 1'b0;
            rd_mode_r <= MODE_PIXEL;
        end else begin
            rd_en_r <= host_req_i.en && !host_req_i.we;
            if (host_req_i.en && !host_req_i.we) begin
                rd_mode_r <= host_req_i.mode;    // hold mode for the data cycle
            end
            if (host_req_i.en && host_req_i.we) begin
                case (host_req_i.mode)
                    MODE_CTRL:   start_r  <= host_req_i.data[0];
                    MODE_WIDTH:  width_r  <= host_req_i.data[`MF_DIM_W-1:0];
                    MODE_HEIGHT: height_r <= host_req_i.data[`MF_DIM_W-1:0];
                    default: ;
                endcase
            end
        end
    end

    // host owns source writes and result reads while idle
    always_comb begin
        src_req_o = busy_i ? src_req_i :
                    '{en: pix_acc && host_req_i.we, we: host_req_i.we,
                      addr: host_req_i.addr, data: host_req_i.data[`MF_PIX_W-1:0]};
        res_req_o = busy_i ? res_req_i :
                    '{en: pix_acc && !host_req_i.we, we: 1'b0,
                      addr: host_req_i.addr, data: '0};
    end

    always_comb begin
        douta_o = '0;
        if (rd_en_r) begin
            if (rd_mode_r == MODE_CTRL) douta_o = bus_t'(done_i);
            else if (rd_mode_r == MODE_PIXEL && done_i) douta_o = bus_t'(res_rdata_i);
        end
    end

    assign start_o  = start_r;
    assign width_o  = width_r;
    assign height_o = height_r;

endmodule

//--- source/median_filter_unit.sv
/* 3x3 median filter top level */

module median_filter_unit (
    input  logic              CLK,
    input  logic              RST,
    input  mf_pkg::host_req_t host_req_i,
    output mf_pkg::bus_t      douta_o
);
    import mf_pkg::*;

    ram_req_t src_req;
    ram_req_t res_req;
    ram_req_t fetch_req;
    ram_req_t seq_req;
    pixel_t   src_rdata;
    pixel_t   res_rdata;
    logic     start;
    dim_t     width;
    dim_t     height;
    logic     busy;
    logic     done;
    logic     fetch_start;
    pix_pos_t pos;
    logic     window_valid;
    window_t  window;
    logic     median_valid;
    pixel_t   median;

    mf_host_port u_host_port (
        .CLK         (CLK),
        .RST         (RST),
        .host_req_i  (host_req_i),
        .busy_i      (busy),
        .done_i      (done),
        .src_req_i   (fetch_req),
        .res_req_i   (seq_req),
        .res_rdata_i (res_rdata),
        .src_req_o   (src_req),
        .res_req_o   (res_req),
        .start_o     (start),
        .width_o     (width),
        .height_o    (height),
        .douta_o     (douta_o)
    );

    mf_sequencer u_sequencer (
        .CLK            (CLK),
        .RST            (RST),
        .start_i        (start),
        .width_i        (width),
        .height_i       (height),
        .median_valid_i (median_valid),
        .median_i       (median),
        .busy_o         (busy),
        .done_o         (done),
        .fetch_start_o  (fetch_start),
        .pos_o          (pos),
        .res_req_o      (seq_req)
    );

    mf_window_fetch u_window_fetch (
        .CLK            (CLK),
        .RST            (RST),
        .fetch_start_i  (fetch_start),
        .pos_i          (pos),
        .width_i        (width),
        .height_i       (height),
        .src_rdata_i    (src_rdata),
        .src_req_o      (fetch_req),
        .window_valid_o (window_valid),
        .window_o       (window)
    );

    mf_median_sort u_median_sort (
        .CLK            (CLK),
        .RST            (RST),
        .window_valid_i (window_valid),
        .window_i       (window),
        .median_valid_o (median_valid),
        .median_o       (median)
    );

    mf_pixel_ram src_ram (.CLK(CLK), .req_i(src_req), .rdata_o(src_rdata));

    mf_pixel_ram res_ram (.CLK(CLK), .req_i(res_req), .rdata_o(res_rdata));

endmodule

//--- tb/mf_sva.sv
/* median filter assertions */

module mf_sva (
    input logic             CLK,
    input logic             RST,
    input logic             busy_i,
    input logic             done_i,
    input logic             fetch_start_i,
    input logic             window_valid_i,
    input mf_pkg::ram_req_t seq_req_i,
    input mf_pkg::ram_req_t src_req_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // one pixel in flight
    a_fetch_single: assert property (@(posedge CLK) disable iff (!RST)
        fetch_start_i |=> (!fetch_start_i) throughout (window_valid_i [->1]))
        else $error("fetch_start while a fetch is in progress");

    // nothing left running once the frame is done
    a_busy_done: assert property (@(posedge CLK) disable iff (!RST)
        !(done_i && (busy_i || fetch_start_i)))
        else $error("busy or fetch_start high while done");

    a_window_latency: assert property (@(posedge CLK) disable iff (!RST)
        fetch_start_i |-> ##10 window_valid_i)
        else $error("window_valid missing 10 cycles after fetch_start");

    a_window_origin: assert property (@(posedge CLK) disable iff (!RST)
        window_valid_i |-> $past(fetch_start_i, 10))
        else $error("window_valid without fetch_start 10 cycles before");

    // write lands in the sorter's output slot
    a_write_exec: assert property (@(posedge CLK) disable iff (!RST)
        seq_req_i.en |-> busy_i && $past(window_valid_i, 9))
        else $error("result write outside EXEC or not 9 cycles after window_valid");

    a_src_locked: assert property (@(posedge CLK) disable iff (!RST)
        busy_i |-> !(src_req_i.en && src_req_i.we))
        else $error("source memory written while busy");

endmodule

bind median_filter_unit mf_sva u_sva (
    .CLK            (CLK),
    .RST            (RST),
    .busy_i         (busy),
    .done_i         (done),
    .fetch_start_i  (fetch_start),
    .window_valid_i (window_valid),
    .seq_req_i      (seq_req),
    .src_req_i      (src_req)
);

//--- tb/tb_median_filter.sv
/* median filter testbench */

`include "mf_config.svh"

module tb_median_filter;
    timeunit 1ns;
    timeprecision 1ps;

    import mf_pkg::*;

    typedef enum logic [1:0] {
        FILL_CONST,
        FILL_RAMP,
        FILL_RAND
    } fill_t;

    typedef struct packed {
        dim_t  width;
        dim_t  height;
        fill_t fill;
        logic  done;    // status bit expected once the frame ends
    } img_case_t;

    localparam int NUM_CASES = 5;
    localparam int CLK_HALF  = 10;

    img_case_t cases [NUM_CASES] = '{
        '{width: 1, height: 1, fill: FILL_CONST, done: 1'b1},
        '{width: 3, height: 3, fill: FILL_RAMP,  done: 1'b1},
        '{width: 4, height: 3, fill: FILL_CONST, done: 1'b1},
        '{width: 5, height: 4, fill: FILL_RAND,  done: 1'b1},
        '{width: 8, height: 6, fill: FILL_RAND,  done: 1'b1}
    };

    logic      CLK;
    logic      RST;
    host_req_t host_req;
    bus_t      douta;

    pixel_t img [2 ** `MF_ADDR_W];    // source image as the host wrote it
    int     cur_w;
    int     cur_h;
    integer seed = 32'h11368ec9;
    int     cycles;
    int     limit;

    median_filter_unit DUT (
        .CLK        (CLK),
        .RST        (RST),
        .host_req_i (host_req),
        .douta_o    (douta)
    );

    initial CLK = 1'b0;
    always #CLK_HALF CLK = ~CLK;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bus(input bus_t got, input bus_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_pixel(input pixel_t got, input pixel_t exp, input string what);
        if (got !== exp) begin
            abort_run($sformatf("[FAIL] %0t ns: %s, got %h expected %h", $time, what, got, exp));
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic host_write(input host_mode_t mode, input pix_addr_t addr, input bus_t data);
        host_req.en   = 1'b1;
        host_req.we   = 1'b1;
        host_req.mode = mode;
        host_req.addr = addr;
        host_req.data = data;
        @(negedge CLK);
        host_req.en = 1'b0;
        host_req.we = 1'b0;
    endtask

    task automatic host_read(input host_mode_t mode, input pix_addr_t addr, output bus_t data);
        host_req.en   = 1'b1;
        host_req.we   = 1'b0;
        host_req.mode = mode;
        host_req.addr = addr;
        host_req.data = '0;
        @(negedge CLK);
        data        = douta;    // data cycle follows the request edge
        host_req.en = 1'b0;
    endtask

    // zero-padded 3x3 median of the stored image
    function automatic pixel_t median_ref(input int row, input int col);
        pixel_t v [`MF_WIN];
        pixel_t t;
        int     k;
        int     rr;
        int     cc;
        k = 0;
        for (int dr = -1; dr <= 1; dr++) begin
            for (int dc = -1; dc <= 1; dc++) begin
                rr = row + dr;
                cc = col + dc;
                if (rr >= 0 && rr < cur_h && cc >= 0 && cc < cur_w) v[k] = img[rr * cur_w + cc];
                else v[k] = '0;
                k++;
            end
        end
        for (int i = 1; i < `MF_WIN; i++) begin
            t = v[i];
            k = i;
            while (k > 0 && v[k-1] > t) begin
                v[k] = v[k-1];
                k--;
            end
            v[k] = t;
        end
        return v[`MF_WIN/2];
    endfunction

    task automatic run_case(input img_case_t cs);
        bus_t rd;
        int   npix;
        npix  = int'(cs.width) * int'(cs.height);
        cur_w = int'(cs.width);
        cur_h = int'(cs.height);
        for (int i = 0; i < npix; i++) begin
            case (cs.fill)
                FILL_CONST: img[i] = 8'h5a;
                FILL_RAMP:  img[i] = pixel_t'(i * 29 + 7);
                default:    img[i] = pixel_t'($random(seed));
            endcase
            host_write(MODE_PIXEL, pix_addr_t'(i), bus_t'(img[i]));
        end
        host_write(MODE_WIDTH, '0, bus_t'(cs.width));
        host_write(MODE_HEIGHT, '0, bus_t'(cs.height));
        host_write(MODE_CTRL, '0, 32'd1);
        host_read(MODE_PIXEL, '0, rd);
        check_bus(rd, '0, "pixel read while busy");
        host_write(MODE_PIXEL, '0, bus_t'(~img[0]));    // engine owns memory, dropped
        do begin
            host_read(MODE_CTRL, '0, rd);
            if (!rd[0]) check_bus(rd, '0, "status while busy");
        end while (!rd[0]);
        check_bus(rd, bus_t'(cs.done), "status at end of frame");
        for (int r = 0; r < cur_h; r++) begin
            for (int c = 0; c < cur_w; c++) begin
                host_read(MODE_PIXEL, pix_addr_t'(r * cur_w + c), rd);
                check_bus(rd & ~bus_t'({`MF_PIX_W{1'b1}}), '0, "result zero extension");
                check_pixel(pixel_t'(rd), median_ref(r, c),
                            $sformatf("%0dx%0d result row %0d col %0d", cur_w, cur_h, r, c));
            end
        end
        // done holds until start is cleared
        host_read(MODE_CTRL, '0, rd);
        check_bus(rd, bus_t'(cs.done), "status held after readout");
        host_write(MODE_CTRL, '0, '0);
        @(negedge CLK);
        host_read(MODE_CTRL, '0, rd);
        check_bus(rd, '0, "status after start cleared");
    endtask

    initial begin
        limit = 200;
        for (int i = 0; i < NUM_CASES; i++) begin
            limit += (32 + 4) * int'(cases[i].width) * int'(cases[i].height);
        end
        cycles = 0;
        while (cycles < limit) begin
            @(posedge CLK);
            cycles++;
        end
        abort_run($sformatf("Timeout: the run did not finish within %0d clock cycles", limit));
    end

    initial begin
        bus_t rd;
        host_req = '0;
        RST      = 1'b0;
        repeat (8) @(posedge CLK);
        @(negedge CLK);
        RST = 1'b1;
        @(negedge CLK);
        host_read(MODE_CTRL, '0, rd);
        check_bus(rd, '0, "status after reset");
        host_read(MODE_PIXEL, '0, rd);
        check_bus(rd, '0, "pixel read after reset");
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(cases[i]);
        end
        $display("Test passed");
        $finish;
    end

endmodule

//--- compile.f
+incdir+source
source/mf_pkg.sv
source/mf_pixel_ram.sv
source/mf_median_sort.sv
source/mf_window_fetch.sv
source/mf_sequencer.sv
source/mf_host_port.sv
source/median_filter_unit.sv
tb/mf_sva.sv
tb/tb_median_filter.sv

//--- Bender.yml
package:
  name: median_filter

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/mf_pkg.sv
      - source/mf_pixel_ram.sv
      - source/mf_median_sort.sv
      - source/mf_window_fetch.sv
      - source/mf_sequencer.sv
      - source/mf_host_port.sv
      - source/median_filter_unit.sv
  - target: test
    include_dirs:
      - source
    files:
      - tb/mf_sva.sv
      - tb/tb_median_filter.sv
